//--- design/air_proto_pkg.sv
// Air-interface definitions for the tag backscatter transmitter
// Reply kinds, protocol word types, error codes and CRC-16 constants

package air_proto_pkg;

    // ****************************************
    // Reply kinds handled by the transmitter
    // ****************************************
    typedef enum logic [1:0]
    {
        reply_rn16   = 2'd0,
        reply_handle = 2'd1,
        reply_error  = 2'd2
    } reply_kind_e;

    // Protocol word for RN16, handle and CRC
    typedef logic [15:0] word_t;

    // Error code carried by the error reply
    typedef logic [7:0] err_code_t;

    // Named error codes
    localparam err_code_t ERR_OTHER       = 8'h00;
    localparam err_code_t ERR_OVERRUN     = 8'h03;
    localparam err_code_t ERR_LOCKED      = 8'h04;
    localparam err_code_t ERR_INSUF_POWER = 8'h0B;

    // ****************************************
    // CRC-16 as used on the reply link
    // ****************************************
    // Register preset before the first body bit
    localparam word_t CRC_PRESET = 16'hFFFF;

    // x^16 + x^12 + x^5 + 1
    localparam word_t CRC_POLY = 16'h1021;

    // Body lengths in bits without CRC and dummy bit
    localparam int BODY_BITS_RN16   = 16;
    localparam int BODY_BITS_HANDLE = 16;

    // Header bit, error code, then handle
    localparam int BODY_BITS_ERROR  = 25;

endpackage

//--- design/line_code_pkg.sv
// Line-code definitions for the FM0 backscatter path
// Symbol kinds, preamble pattern and framer phases

package line_code_pkg;

    // ****************************************
    // Symbol stream between framer and encoder
    // ****************************************
    // A violation symbol keeps the line level for both halves
    typedef enum logic
    {
        sym_data      = 1'b0,
        sym_violation = 1'b1
    } sym_kind_e;

    // Framer phases, walked in this order
    typedef enum logic [2:0]
    {
        ph_idle     = 3'd0,
        ph_pilot    = 3'd1,
        ph_preamble = 3'd2,
        ph_body     = 3'd3,
        ph_crc      = 3'd4,
        ph_dummy    = 3'd5
    } frame_phase_e;

    // ****************************************
    // FM0 preamble 1,0,1,0,v,1
    // ****************************************
    // Index 0 is sent first; the bit under the violation is not encoded
    localparam logic [0:5] PREAMBLE_BITS = 6'b101001;

    // Position of the violation symbol
    localparam int PREAMBLE_VIOL = 4;

endpackage

//--- design/reply_latch.sv
// Reply request latch
// Accepts a start while idle, holds the reply fields for the whole
// frame and keeps busy up until the encoder reports the frame end

module reply_latch
(
    input  logic                     data_pulse,
    input  logic                     enc_rst,
    input  logic                     start,
    input  air_proto_pkg::reply_kind_e reply_kind,
    input  logic                     trext,
    input  air_proto_pkg::word_t     rn16,
    input  air_proto_pkg::word_t     handle,
    input  air_proto_pkg::err_code_t err_code,
    input  logic                     frame_end,
    output logic                     frame_go,
    output logic                     busy,
    output air_proto_pkg::reply_kind_e kind_q,
    output logic                     trext_q,
    output air_proto_pkg::word_t     rn16_q,
    output air_proto_pkg::word_t     handle_q,
    output air_proto_pkg::err_code_t err_code_q
);

    logic take_q;
    logic busy_q;
    logic accept;

    // Busy drops together with the frame end pulse
    assign busy = busy_q & ~frame_end;

    // A pending take also blocks a second start
    assign accept = start & ~busy & ~take_q;

    always_ff @(posedge data_pulse or negedge enc_rst)
    begin
        if (!enc_rst)
        begin
            take_q   <= 1'b0;
            frame_go <= 1'b0;
            busy_q   <= 1'b0;
        end
        else
        begin
            take_q   <= accept;
            frame_go <= take_q;
            if (take_q)
                busy_q <= 1'b1;
            else if (frame_end)
                busy_q <= 1'b0;
        end
    end

    // Request fields held until the next accepted start
    always_ff @(posedge data_pulse)
    begin
        if (accept)
        begin
            kind_q     <= reply_kind;
            trext_q    <= trext;
            rn16_q     <= rn16;
            handle_q   <= handle;
            err_code_q <= err_code;
        end
    end

endmodule

//--- design/reply_framer.sv
// Reply framer
// Walks pilot, preamble, body, CRC and dummy bit, one symbol every
// two cycles, and runs the CRC generator alongside the body

module reply_framer
#(
    parameter int pilot_zeros = 12
)
(
    input  logic                       data_pulse,
    input  logic                       enc_rst,
    input  logic                       frame_go,
    input  air_proto_pkg::reply_kind_e kind_q,
    input  logic                       trext_q,
    input  air_proto_pkg::word_t       rn16_q,
    input  air_proto_pkg::word_t       handle_q,
    input  air_proto_pkg::err_code_t   err_code_q,
    input  logic                       crc_bit,
    output logic                       crc_clear,
    output logic                       crc_feed,
    output logic                       crc_feed_bit,
    output logic                       crc_emit,
    output logic                       sym_strobe,
    output logic                       sym_bit,
    output line_code_pkg::sym_kind_e   sym_kind,
    output logic                       frame_last
);

    import air_proto_pkg::*;
    import line_code_pkg::*;

    localparam int         BODY_MSB     = BODY_BITS_ERROR - 1;
    localparam logic [4:0] PILOT_LAST   = 5'(pilot_zeros - 1);
    localparam logic [4:0] PRE_LAST     = 5'($bits(PREAMBLE_BITS) - 1);
    localparam logic [4:0] CRC_LAST     = 5'($bits(word_t) - 1);

    frame_phase_e           phase;
    frame_phase_e           eff_phase;
    frame_phase_e           nxt_phase;
    logic [4:0]             idx;
    logic [4:0]             nxt_idx;
    logic [4:0]             body_last;
    logic                   half;
    logic                   fire;
    logic                   cur_bit;
    sym_kind_e              cur_kind;
    logic [BODY_MSB:0]      body_sr;

    // In idle the first symbol comes from the pilot or the preamble
    always_comb
    begin
        if (phase == ph_idle)
            eff_phase = trext_q ? ph_pilot : ph_preamble;
        else
            eff_phase = phase;
    end

    // One symbol per two cycles with the first on frame_go
    assign fire = (phase == ph_idle) ? frame_go : half;

    always_comb
    begin
        case (kind_q)
            reply_error:  body_last = 5'(BODY_BITS_ERROR - 1);
            reply_handle: body_last = 5'(BODY_BITS_HANDLE - 1);
            default:      body_last = 5'(BODY_BITS_RN16 - 1);
        endcase
    end

    // ****************************************
    // Current symbol and next position
    // ****************************************
    always_comb
    begin
        cur_bit   = 1'b0;
        cur_kind  = sym_data;
        nxt_phase = eff_phase;
        nxt_idx   = idx + 5'd1;
        case (eff_phase)
            ph_pilot:
            begin
                if (idx == PILOT_LAST)
                begin
                    nxt_phase = ph_preamble;
                    nxt_idx   = 5'd0;
                end
            end
            ph_preamble:
            begin
                cur_bit = PREAMBLE_BITS[idx[2:0]];
                if (idx == 5'(PREAMBLE_VIOL))
                    cur_kind = sym_violation;
                if (idx == PRE_LAST)
                begin
                    nxt_phase = ph_body;
                    nxt_idx   = 5'd0;
                end
            end
            ph_body:
            begin
                cur_bit = body_sr[BODY_MSB];
                if (idx == body_last)
                begin
                    nxt_phase = ph_crc;
                    nxt_idx   = 5'd0;
                end
            end
            ph_crc:
            begin
                // Complemented CRC sent MSB first
                cur_bit = crc_bit;
                if (idx == CRC_LAST)
                begin
                    nxt_phase = ph_dummy;
                    nxt_idx   = 5'd0;
                end
            end
            ph_dummy:
            begin
                cur_bit   = 1'b1;
                nxt_phase = ph_idle;
                nxt_idx   = 5'd0;
            end
            default:
            begin
                nxt_phase = ph_idle;
                nxt_idx   = 5'd0;
            end
        endcase
    end

    // CRC control follows the symbol being sent
    assign crc_clear    = (phase == ph_idle) && frame_go;
    assign crc_feed     = fire && (eff_phase == ph_body);
    assign crc_feed_bit = body_sr[BODY_MSB];
    assign crc_emit     = fire && (eff_phase == ph_crc);

    always_ff @(posedge data_pulse or negedge enc_rst)
    begin
        if (!enc_rst)
        begin
            phase      <= ph_idle;
            idx        <= 5'd0;
            half       <= 1'b0;
            sym_strobe <= 1'b0;
            frame_last <= 1'b0;
        end
        else
        begin
            sym_strobe <= fire;
            frame_last <= fire && (eff_phase == ph_dummy);
            if (fire)
            begin
                phase <= nxt_phase;
                idx   <= nxt_idx;
                half  <= 1'b0;
            end
            else if (phase != ph_idle)
                half <= 1'b1;
        end
    end

    always_ff @(posedge data_pulse)
    begin
        if (fire)
        begin
            sym_bit  <= cur_bit;
            sym_kind <= cur_kind;
        end
    end

    // Body register loaded by kind and shifted MSB first
    always_ff @(posedge data_pulse)
    begin
        if (crc_clear)
        begin
            case (kind_q)
                reply_error:
                    body_sr <= {1'b1, err_code_q, handle_q};
                reply_handle:
                    body_sr <= {handle_q, {(BODY_BITS_ERROR - BODY_BITS_HANDLE){1'b0}}};
                default:
                    body_sr <= {rn16_q, {(BODY_BITS_ERROR - BODY_BITS_RN16){1'b0}}};
            endcase
        end
        else if (crc_feed)
            body_sr <= {body_sr[BODY_MSB-1:0], 1'b0};
    end

endmodule

//--- design/crc16_gen.sv
// CRC-16 generator
// Accumulates the body one bit at a time and then shifts out the
// ones' complement of the result, MSB first

module crc16_gen
(
    input  logic data_pulse,
    input  logic enc_rst,
    input  logic crc_clear,
    input  logic crc_feed,
    input  logic crc_feed_bit,
    input  logic crc_emit,
    output logic crc_bit
);

    import air_proto_pkg::*;

    word_t crc_reg;
    logic  fb;

    // Feedback of the serial divider
    assign fb = crc_feed_bit ^ crc_reg[15];

    // Sent bits are the inverted register
    assign crc_bit = ~crc_reg[15];

    always_ff @(posedge data_pulse or negedge enc_rst)
    begin
        if (!enc_rst)
            crc_reg <= CRC_PRESET;
        else if (crc_clear)
            crc_reg <= CRC_PRESET;
        else if (crc_feed)
        begin
            if (fb)
                crc_reg <= {crc_reg[14:0], 1'b0} ^ CRC_POLY;
            else
                crc_reg <= {crc_reg[14:0], 1'b0};
        end
        else if (crc_emit)
            crc_reg <= {crc_reg[14:0], 1'b0};
    end

endmodule

//--- design/fm0_encoder.sv
// FM0 encoder
// Turns each symbol into two half-symbols on dout, inserts the
// violation where asked and reports the end of the frame

module fm0_encoder
(
    input  logic                     data_pulse,
    input  logic                     enc_rst,
    input  logic                     sym_strobe,
    input  logic                     sym_bit,
    input  line_code_pkg::sym_kind_e sym_kind,
    input  logic                     frame_last,
    output logic                     dout,
    output logic                     frame_end
);

    import line_code_pkg::*;

    logic      half2;
    logic      last_q;
    logic      end_due;
    logic      bit_q;
    sym_kind_e cur_kind;
    logic      first_half;
    logic      second_half;

    // ****************************************
    // FM0 rule on the current line level
    // ****************************************
    // Data symbols invert at the boundary, violations do not
    assign first_half = (sym_kind == sym_data) ? ~dout : dout;

    // Zero inverts again mid-symbol
    assign second_half = (cur_kind == sym_data && !bit_q) ? ~dout : dout;

    always_ff @(posedge data_pulse or negedge enc_rst)
    begin
        if (!enc_rst)
        begin
            dout      <= 1'b0;
            half2     <= 1'b0;
            last_q    <= 1'b0;
            end_due   <= 1'b0;
            frame_end <= 1'b0;
        end
        else
        begin
            half2     <= sym_strobe;
            end_due   <= half2 & last_q;
            frame_end <= end_due;
            if (sym_strobe)
            begin
                dout   <= first_half;
                last_q <= frame_last;
            end
            else if (half2)
                dout <= second_half;
            else if (end_due)
                // Line back to idle level
                dout <= 1'b0;
        end
    end

    // Symbol held for its second half
    always_ff @(posedge data_pulse)
    begin
        if (sym_strobe)
        begin
            bit_q    <= sym_bit;
            cur_kind <= sym_kind;
        end
    end

endmodule

//--- design/backscatter_tx.sv
// Backscatter transmitter top level
// Request latch, reply framer, CRC-16 generator and FM0 encoder

module backscatter_tx
#(
    parameter int pilot_zeros = 12
)
(
    input  logic                       data_pulse,
    input  logic                       enc_rst,
    input  logic                       start,
    input  air_proto_pkg::reply_kind_e reply_kind,
    input  logic                       trext,
    input  air_proto_pkg::word_t       rn16,
    input  air_proto_pkg::word_t       handle,
    input  air_proto_pkg::err_code_t   err_code,
    output logic                       dout,
    output logic                       busy,
    output logic                       done
);

    import air_proto_pkg::*;
    import line_code_pkg::*;

    // Latched request
    logic        frame_go;
    reply_kind_e kind_q;
    logic        trext_q;
    word_t       rn16_q;
    word_t       handle_q;
    err_code_t   err_code_q;

    // CRC control
    logic        crc_clear;
    logic        crc_feed;
    logic        crc_feed_bit;
    logic        crc_emit;
    logic        crc_bit;

    // Symbol stream
    logic        sym_strobe;
    logic        sym_bit;
    sym_kind_e   sym_kind;
    logic        frame_last;
    logic        frame_end;

    assign done = frame_end;

    reply_latch u_latch
    (
        .data_pulse (data_pulse),
        .enc_rst    (enc_rst),
        .start      (start),
        .reply_kind (reply_kind),
        .trext      (trext),
        .rn16       (rn16),
        .handle     (handle),
        .err_code   (err_code),
        .frame_end  (frame_end),
        .frame_go   (frame_go),
        .busy       (busy),
        .kind_q     (kind_q),
        .trext_q    (trext_q),
        .rn16_q     (rn16_q),
        .handle_q   (handle_q),
        .err_code_q (err_code_q)
    );

    reply_framer #(.pilot_zeros(pilot_zeros)) u_framer
    (
        .data_pulse   (data_pulse),
        .enc_rst      (enc_rst),
        .frame_go     (frame_go),
        .kind_q       (kind_q),
        .trext_q      (trext_q),
        .rn16_q       (rn16_q),
        .handle_q     (handle_q),
        .err_code_q   (err_code_q),
        .crc_bit      (crc_bit),
        .crc_clear    (crc_clear),
        .crc_feed     (crc_feed),
        .crc_feed_bit (crc_feed_bit),
        .crc_emit     (crc_emit),
        .sym_strobe   (sym_strobe),
        .sym_bit      (sym_bit),
        .sym_kind     (sym_kind),
        .frame_last   (frame_last)
    );

    crc16_gen u_crc
    (
        .data_pulse   (data_pulse),
        .enc_rst      (enc_rst),
        .crc_clear    (crc_clear),
        .crc_feed     (crc_feed),
        .crc_feed_bit (crc_feed_bit),
        .crc_emit     (crc_emit),
        .crc_bit      (crc_bit)
    );

    fm0_encoder u_fm0
    (
        .data_pulse (data_pulse),
        .enc_rst    (enc_rst),
        .sym_strobe (sym_strobe),
        .sym_bit    (sym_bit),
        .sym_kind   (sym_kind),
        .frame_last (frame_last),
        .dout       (dout),
        .frame_end  (frame_end)
    );

endmodule

//--- sim/backscatter_tx_chk.sv
// Protocol checks on the transmitter ports
// done is a single-cycle pulse that closes a busy period, and the
// line stays at idle level outside a frame

module backscatter_tx_chk
(
    input logic data_pulse,
    input logic enc_rst,
    input logic busy,
    input logic done,
    input logic dout
);

    // Count of failed assertions
    int fail_count = 0;

    // Frame end is a single-cycle pulse
    done_one_cycle: assert property (@(posedge data_pulse) disable iff (!enc_rst)
        done |=> !done)
        else
        begin
            $error("done stayed high for more than one cycle");
            fail_count++;
        end

    // A frame end always closes a busy period
    done_after_busy: assert property (@(posedge data_pulse) disable iff (!enc_rst)
        done |-> $past(busy))
        else
        begin
            $error("done pulsed without busy in the previous cycle");
            fail_count++;
        end

    // Idle line outside a frame
    idle_line: assert property (@(posedge data_pulse) disable iff (!enc_rst)
        !busy |-> !dout)
        else
        begin
            $error("dout high while busy is low");
            fail_count++;
        end

endmodule

bind backscatter_tx backscatter_tx_chk u_chk
(
    .data_pulse (data_pulse),
    .enc_rst    (enc_rst),
    .busy       (busy),
    .done       (done),
    .dout       (dout)
);

//--- sim/backscatter_tx_tb.sv
// Testbench for the backscatter transmitter
// Random replies from a fixed seed, decoded from dout and checked
// against a bit-level model of framing, CRC-16 and FM0

module backscatter_tx_tb;

    import air_proto_pkg::*;

    localparam int PILOT_ZEROS  = 12;
    localparam int NUM_REQUESTS = 40;
    localparam int CYCLE_LIMIT  = NUM_REQUESTS * 140 + 100;

    // Preamble 1,0,1,0,v,1; the entry under the violation is unused
    localparam logic [0:5] PREAMBLE_REF = 6'b101001;

    logic        data_pulse;
    logic        enc_rst;
    logic        start;
    reply_kind_e reply_kind;
    logic        trext;
    word_t       rn16;
    word_t       handle;
    err_code_t   err_code;
    logic        dout;
    logic        busy;
    logic        done;

    int   cycle_count = 0;
    int   done_count = 0;
    int   accepted_count;
    int   n_halves;
    logic halves [0:255];
    logic sym_bits [0:127];

    backscatter_tx #(.pilot_zeros(PILOT_ZEROS)) UUT
    (
        .data_pulse (data_pulse),
        .enc_rst    (enc_rst),
        .start      (start),
        .reply_kind (reply_kind),
        .trext      (trext),
        .rn16       (rn16),
        .handle     (handle),
        .err_code   (err_code),
        .dout       (dout),
        .busy       (busy),
        .done       (done)
    );

    initial
    begin
        data_pulse = 1'b0;
        forever #5 data_pulse = ~data_pulse;
    end

    // ****************************************
    // Failure reporting and compare tasks
    // ****************************************
    task automatic abort_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic compare_word(input word_t got, input word_t exp, input string what);
        if (got !== exp)
        begin
            $display("ERROR at time %0t: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_code(input err_code_t got, input err_code_t exp, input string what);
        if (got !== exp)
        begin
            $display("ERROR at time %0t: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            $display("ERROR at time %0t: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_count(input int got, input int exp, input string what);
        if (got != exp)
        begin
            $display("ERROR at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    // Watchdog, assertion monitor and done pulse counter
    always @(negedge data_pulse)
    begin
        cycle_count++;
        if (enc_rst && done)
            done_count++;
        if (UUT.u_chk.fail_count != 0)
        begin
            $display("A protocol assertion in the bound checker failed");
            abort_run();
        end
        else if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("Run stopped: no result after %0d cycles", CYCLE_LIMIT);
            abort_run();
        end
    end

    // ****************************************
    // Reference model and helpers
    // ****************************************
    function automatic err_code_t pick_code();
        err_code_t code;
        case ($urandom_range(0, 3))
            0:       code = ERR_OTHER;
            1:       code = ERR_OVERRUN;
            2:       code = ERR_LOCKED;
            default: code = ERR_INSUF_POWER;
        endcase
        return code;
    endfunction

    // Serial CRC-16 over the body MSB first and complemented at the end
    function automatic word_t crc_model(input logic [24:0] body, input int len);
        word_t crc;
        logic  fb;
        crc = CRC_PRESET;
        for (int i = len - 1; i >= 0; i--)
        begin
            fb  = body[i] ^ crc[15];
            crc = {crc[14:0], 1'b0};
            if (fb)
                crc = crc ^ CRC_POLY;
        end
        return ~crc;
    endfunction

    // Decoded symbols packed MSB first
    function automatic word_t gather_bits(input int first, input int width);
        word_t w;
        w = '0;
        for (int i = 0; i < width; i++)
            w = {w[14:0], sym_bits[first + i]};
        return w;
    endfunction

    task automatic scramble_inputs();
        reply_kind = reply_kind_e'($urandom_range(0, 2));
        trext      = 1'($urandom_range(0, 1));
        rn16       = 16'($urandom);
        handle     = 16'($urandom);
        err_code   = 8'($urandom);
    endtask

    task automatic check_idle(input string when);
        compare_bit(dout, 1'b0, {"dout ", when});
        compare_bit(busy, 1'b0, {"busy ", when});
        compare_bit(done, 1'b0, {"done ", when});
    endtask

    // ****************************************
    // Start, capture, decode and check one reply
    // ****************************************
    task automatic run_request();
        reply_kind_e kind_v;
        logic        trext_v;
        word_t       rn16_v;
        word_t       handle_v;
        err_code_t   code_v;
        logic [24:0] body;
        int          body_len;
        int          pilot_len;
        int          exp_syms;
        int          viol_idx;
        int          extra_at;
        int          lead;
        int          pos;
        logic        level;
        logic        a;
        logic        b;
        logic        seen_done;

        kind_v   = reply_kind_e'($urandom_range(0, 2));
        trext_v  = 1'($urandom_range(0, 1));
        rn16_v   = 16'($urandom);
        handle_v = 16'($urandom);
        code_v   = pick_code();
        extra_at = $urandom_range(2, 60);

        case (kind_v)
            reply_error:
            begin
                body     = {1'b1, code_v, handle_v};
                body_len = BODY_BITS_ERROR;
            end
            reply_handle:
            begin
                body     = {9'd0, handle_v};
                body_len = BODY_BITS_HANDLE;
            end
            default:
            begin
                body     = {9'd0, rn16_v};
                body_len = BODY_BITS_RN16;
            end
        endcase
        pilot_len = trext_v ? PILOT_ZEROS : 0;
        exp_syms  = pilot_len + 6 + body_len + 16 + 1;
        viol_idx  = pilot_len + 4;

        compare_bit(busy, 1'b0, "busy before an accepted start");
        start      = 1'b1;
        reply_kind = kind_v;
        trext      = trext_v;
        rn16       = rn16_v;
        handle     = handle_v;
        err_code   = code_v;
        accepted_count++;

        // Sample dout each cycle until done
        n_halves  = 0;
        seen_done = 1'b0;
        while (!seen_done)
        begin
            @(negedge data_pulse);
            if (done)
            begin
                seen_done = 1'b1;
                compare_bit(dout, 1'b0, "dout in the done cycle");
                compare_bit(busy, 1'b0, "busy in the done cycle");
            end
            else if (n_halves < 256)
            begin
                halves[n_halves] = dout;
                n_halves++;
                if (n_halves >= 2)
                    compare_bit(busy, 1'b1, "busy during a frame");
            end
            start = 1'b0;
            scramble_inputs();
            // A start while busy must be ignored
            if (!seen_done && n_halves == extra_at && busy)
                start = 1'b1;
        end

        lead = 0;
        while (lead < n_halves && halves[lead] == 1'b0)
            lead++;
        compare_count(lead, 3, "edges from start to first half-symbol");
        compare_count(n_halves - lead, 2 * exp_syms, "half-symbols in the frame");

        // FM0 decode with the line level starting at 0
        level = 1'b0;
        for (int s = 0; s < exp_syms; s++)
        begin
            a = halves[lead + 2 * s];
            b = halves[lead + 2 * s + 1];
            if (s == viol_idx)
            begin
                compare_bit(a, level, "violation first half");
                compare_bit(b, a, "violation second half");
            end
            else
                compare_bit(a, ~level, "FM0 inversion at symbol boundary");
            sym_bits[s] = (a == b);
            level       = b;
        end

        pos = 0;
        while (pos < viol_idx && sym_bits[pos] == 1'b0)
            pos++;
        compare_count(pos, pilot_len, "pilot length");
        for (int i = 0; i < 6; i++)
        begin
            if (i != 4)
                compare_bit(sym_bits[pos + i], PREAMBLE_REF[i], "preamble symbol");
        end
        pos = pos + 6;

        case (kind_v)
            reply_error:
            begin
                compare_bit(sym_bits[pos], 1'b1, "error reply header");
                compare_code(err_code_t'(gather_bits(pos + 1, 8)), code_v, "error code");
                compare_word(gather_bits(pos + 9, 16), handle_v, "handle in error reply");
            end
            reply_handle:
                compare_word(gather_bits(pos, 16), handle_v, "handle");
            default:
                compare_word(gather_bits(pos, 16), rn16_v, "RN16");
        endcase
        pos = pos + body_len;
        compare_word(gather_bits(pos, 16), crc_model(body, body_len), "CRC-16");
        compare_bit(sym_bits[pos + 16], 1'b1, "dummy bit");
    endtask

    // ****************************************
    // Main sequence
    // ****************************************
    initial
    begin
        int gap;
        void'($urandom(94386));
        enc_rst    = 1'b0;
        start      = 1'b0;
        reply_kind = reply_rn16;
        trext      = 1'b0;
        rn16       = '0;
        handle     = '0;
        err_code   = '0;
        accepted_count = 0;

        repeat (4)
        begin
            @(negedge data_pulse);
            check_idle("during reset");
        end
        enc_rst = 1'b1;
        repeat (3)
        begin
            @(negedge data_pulse);
            check_idle("after reset");
            scramble_inputs();
        end

        // A zero gap starts the next reply in the done cycle
        for (int n = 0; n < NUM_REQUESTS; n++)
        begin
            run_request();
            gap = $urandom_range(0, 3);
            repeat (gap)
            begin
                @(negedge data_pulse);
                check_idle("between frames");
                scramble_inputs();
            end
        end

        repeat (4)
        begin
            @(negedge data_pulse);
            check_idle("after the last frame");
        end
        compare_count(done_count, accepted_count, "done pulses against accepted starts");
        if (UUT.u_chk.fail_count != 0)
        begin
            $display("A protocol assertion in the bound checker failed");
            abort_run();
        end
        else
        begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

//--- backscatter_tx.f
design/air_proto_pkg.sv
design/line_code_pkg.sv
design/reply_latch.sv
design/reply_framer.sv
design/crc16_gen.sv
design/fm0_encoder.sv
design/backscatter_tx.sv
sim/backscatter_tx_chk.sv
sim/backscatter_tx_tb.sv
